// File: include/mdu_defs.svh
// widths are fixed by RV32, so changing MDU_XLEN alone does not resize the datapath correctly
`ifndef MDU_DEFS_SVH
`define MDU_DEFS_SVH

// data word width
`define MDU_XLEN 32

// one restoring step per bit of the 33-bit extended magnitude
`define MDU_DIV_STEPS 33

// free slots the consumer grants right after reset
`define MDU_RSP_CREDITS 2

`endif

// File: design/mdu_pkg.sv
// opcode values follow the RV32M funct3 order, so bit 2 marks the divide group
package mdu_pkg;

    // M-extension operations in funct3 order
    typedef enum logic [2:0] {
        op_mul    = 3'd0,
        op_mulh   = 3'd1,
        op_mulhsu = 3'd2,
        op_mulhu  = 3'd3,
        op_div    = 3'd4,
        op_divu   = 3'd5,
        op_rem    = 3'd6,
        op_remu   = 3'd7
    } mdu_op_e;

    // controller FSM
    typedef enum logic [1:0] {
        st_idle,
        st_mul_wait,
        st_div_wait,
        st_hold
    } mdu_state_e;

endpackage

// File: design/mdu_div_if.sv
// results are only valid from done until the next start pulse
`timescale 1ns/1ns
`include "mdu_defs.svh"

interface mdu_div_if (input logic clk);
    logic                   start;
    logic                   done;
    // 33-bit extended operands
    logic [`MDU_XLEN:0]     a;
    logic [`MDU_XLEN:0]     b;
    logic                   is_signed;
    logic [`MDU_XLEN-1:0]   quotient;
    logic [`MDU_XLEN-1:0]   remainder;

    modport ctrl (output start, input done);
    modport dispatch (output a, b, is_signed, input quotient, remainder);
    modport divider (input clk, start, a, b, is_signed, output done, quotient, remainder);
endinterface

// File: design/mdu_ctrl.sv
// one operation in flight at a time; a new request is only legal after req_credit
`timescale 1ns/1ns

module mdu_ctrl
    import mdu_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        req_valid,
    input  logic        is_div,
    input  logic        mul_done,
    input  logic        has_credit,
    output logic        req_credit,
    output logic        load_req,
    output logic        load_rsp,
    output logic        mul_start,
    output logic        rsp_valid,
    mdu_div_if.ctrl     div
);

    mdu_state_e state_q, state_d;
    // request registered last cycle and unit start pending
    logic launch_q;
    // initial credit grant in the second cycle after reset release
    logic started_q;
    logic init_grant_q;

    assign load_req   = (state_q == st_idle) && !launch_q && req_valid;
    // opcode is registered by now, so is_div is valid
    assign mul_start  = launch_q && !is_div;
    assign div.start  = launch_q && is_div;
    assign load_rsp   = ((state_q == st_mul_wait) && mul_done)
                      || ((state_q == st_div_wait) && div.done);
    // response leaves as soon as the consumer has a slot
    assign rsp_valid  = (state_q == st_hold) && has_credit;
    // each response frees the single request slot
    assign req_credit = init_grant_q || rsp_valid;

    always_comb begin
        state_d = state_q;
        case (state_q)
            st_idle: begin
                if (launch_q) begin
                    state_d = is_div ? st_div_wait : st_mul_wait;
                end
            end
            st_mul_wait: if (mul_done) state_d = st_hold;
            st_div_wait: if (div.done) state_d = st_hold;
            st_hold:     if (has_credit) state_d = st_idle;
            default:     state_d = st_idle;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q      <= st_idle;
            launch_q     <= 1'b0;
            started_q    <= 1'b0;
            init_grant_q <= 1'b0;
        end else begin
            state_q      <= state_d;
            launch_q     <= load_req;
            started_q    <= 1'b1;
            init_grant_q <= !started_q;
        end
    end

    // producer must respect the single request credit
    a_req_in_idle: assert property (@(posedge clk) disable iff (!rst_n)
        req_valid |-> (state_q == st_idle) && !launch_q);
    // units only finish what this FSM started
    a_mul_done_wait: assert property (@(posedge clk) disable iff (!rst_n)
        mul_done |-> state_q == st_mul_wait);
    a_div_done_wait: assert property (@(posedge clk) disable iff (!rst_n)
        div.done |-> state_q == st_div_wait);

endmodule

// File: design/mdu_credit_counter.sv
// assumes the consumer never returns more slots than it granted at reset
`timescale 1ns/1ns
`include "mdu_defs.svh"

module mdu_credit_counter (
    input  logic clk,
    input  logic rst_n,
    input  logic take,
    input  logic give,
    output logic has_credit
);

    localparam int CW = $clog2(`MDU_RSP_CREDITS + 1);

    logic [CW-1:0] cnt_q;

    assign has_credit = (cnt_q != '0);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt_q <= CW'(`MDU_RSP_CREDITS);
        end else if (take && !give) begin
            cnt_q <= cnt_q - 1'b1;
        end else if (give && !take) begin
            cnt_q <= cnt_q + 1'b1;
        end
    end

    // response issued with no free consumer slot
    a_no_take_at_zero: assert property (@(posedge clk) disable iff (!rst_n)
        take |-> cnt_q != '0);
    // consumer returned a slot it never gave
    a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
        (give && !take) |-> cnt_q < CW'(`MDU_RSP_CREDITS));

endmodule

// File: design/mdu_dispatch.sv
// rsp_data holds the last result until the next load_rsp, so it stays frozen during hold
`timescale 1ns/1ns
`include "mdu_defs.svh"

module mdu_dispatch
    import mdu_pkg::*;
(
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      load_req,
    input  logic                      load_rsp,
    input  mdu_op_e                   req_op,
    input  logic [`MDU_XLEN-1:0]      req_s1,
    input  logic [`MDU_XLEN-1:0]      req_s2,
    input  logic [2*`MDU_XLEN+1:0]    product,
    output logic                      is_div,
    output logic [`MDU_XLEN:0]        mul_a,
    output logic [`MDU_XLEN:0]        mul_b,
    output logic [`MDU_XLEN-1:0]      rsp_data,
    mdu_div_if.dispatch               div
);

    mdu_op_e              op_q;
    logic [`MDU_XLEN-1:0] s1_q;
    logic [`MDU_XLEN-1:0] s2_q;
    logic                 sext_1;
    logic                 sext_2;
    logic [`MDU_XLEN:0]   ext_1;
    logic [`MDU_XLEN:0]   ext_2;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            op_q <= op_mul;
        end else if (load_req) begin
            op_q <= req_op;
        end
    end

    always_ff @(posedge clk) begin
        if (load_req) begin
            s1_q <= req_s1;
            s2_q <= req_s2;
        end
    end

    assign is_div = op_q[2];

    // sign rule per opcode; mulhsu treats s2 as unsigned
    assign sext_1 = (op_q == op_mul) || (op_q == op_mulh) || (op_q == op_mulhsu)
                 || (op_q == op_div) || (op_q == op_rem);
    assign sext_2 = (op_q == op_mul) || (op_q == op_mulh)
                 || (op_q == op_div) || (op_q == op_rem);
    assign ext_1  = {sext_1 & s1_q[`MDU_XLEN-1], s1_q};
    assign ext_2  = {sext_2 & s2_q[`MDU_XLEN-1], s2_q};

    // both units see the same extended operands
    assign mul_a         = ext_1;
    assign mul_b         = ext_2;
    assign div.a         = ext_1;
    assign div.b         = ext_2;
    assign div.is_signed = (op_q == op_div) || (op_q == op_rem);

    always_ff @(posedge clk) begin
        if (load_rsp) begin
            case (op_q)
                op_mul:             rsp_data <= product[`MDU_XLEN-1:0];
                op_div, op_divu:    rsp_data <= div.quotient;
                op_rem, op_remu:    rsp_data <= div.remainder;
                // mulh, mulhsu, mulhu
                default:            rsp_data <= product[2*`MDU_XLEN-1:`MDU_XLEN];
            endcase
        end
    end

endmodule

// File: design/mdu_multiplier.sv
// fixed two-cycle latency from mul_start to mul_done without stall
`timescale 1ns/1ns
`include "mdu_defs.svh"

module mdu_multiplier (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      mul_start,
    input  logic [`MDU_XLEN:0]        mul_a,
    input  logic [`MDU_XLEN:0]        mul_b,
    output logic [2*`MDU_XLEN+1:0]    product,
    output logic                      mul_done
);

    logic [2*`MDU_XLEN+1:0] prod_s1;
    logic                   vld_s1;

    // valid bits follow the data through both stages
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            vld_s1   <= 1'b0;
            mul_done <= 1'b0;
        end else begin
            vld_s1   <= mul_start;
            mul_done <= vld_s1;
        end
    end

    // stage 1 does the 33x33 signed multiply
    // stage 2 is a retiming register
    always_ff @(posedge clk) begin
        prod_s1 <= $signed(mul_a) * $signed(mul_b);
        product <= prod_s1;
    end

endmodule

// File: design/mdu_divider.sv
// fixed latency of MDU_DIV_STEPS+1 cycles from start to done without early out
`timescale 1ns/1ns
`include "mdu_defs.svh"

module mdu_divider (
    input  logic        clk,
    input  logic        rst_n,
    mdu_div_if.divider  div
);

    localparam int W     = `MDU_XLEN + 1;
    localparam int CNT_W = $clog2(`MDU_DIV_STEPS);

    logic                 busy_q;
    logic                 done_q;
    logic [CNT_W-1:0]     cnt_q;
    // partial remainder with the quotient shifting in behind the dividend
    logic [W-1:0]         rem_q;
    logic [W-1:0]         quo_q;
    logic [W-1:0]         dvs_q;
    logic [`MDU_XLEN-1:0] dvd_q;
    logic                 neg_quo_q;
    logic                 neg_rem_q;
    logic                 zero_q;
    logic                 a_neg;
    logic                 b_neg;
    logic [W-1:0]         a_mag;
    logic [W-1:0]         b_mag;
    logic [W:0]           rem_sh;
    logic [W:0]           diff;
    logic [W-1:0]         quo_fix;
    logic [W-1:0]         rem_fix;

    assign a_neg = div.is_signed & div.a[W-1];
    assign b_neg = div.is_signed & div.b[W-1];
    // most negative 32-bit value still fits as a 33-bit magnitude
    assign a_mag = a_neg ? -div.a : div.a;
    assign b_mag = b_neg ? -div.b : div.b;

    // one restoring step
    assign rem_sh = {rem_q, quo_q[W-1]};
    assign diff   = rem_sh - {1'b0, dvs_q};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy_q <= 1'b0;
            done_q <= 1'b0;
            cnt_q  <= '0;
        end else begin
            done_q <= 1'b0;
            if (div.start) begin
                busy_q <= 1'b1;
                cnt_q  <= '0;
            end else if (busy_q) begin
                cnt_q <= cnt_q + 1'b1;
                if (cnt_q == CNT_W'(`MDU_DIV_STEPS - 1)) begin
                    busy_q <= 1'b0;
                    done_q <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (div.start) begin
            rem_q     <= '0;
            quo_q     <= a_mag;
            dvs_q     <= b_mag;
            dvd_q     <= div.a[`MDU_XLEN-1:0];
            neg_quo_q <= a_neg ^ b_neg;
            neg_rem_q <= a_neg;
            zero_q    <= (div.b == '0);
        end else if (busy_q) begin
            // diff sign bit set means the trial subtract failed
            if (!diff[W]) begin
                rem_q <= diff[W-1:0];
                quo_q <= {quo_q[W-2:0], 1'b1};
            end else begin
                rem_q <= rem_sh[W-1:0];
                quo_q <= {quo_q[W-2:0], 1'b0};
            end
        end
    end

    // truncating division gives the remainder the dividend sign
    assign quo_fix = neg_quo_q ? -quo_q : quo_q;
    assign rem_fix = neg_rem_q ? -rem_q : rem_q;

    // RISC-V divide by zero results
    assign div.quotient  = zero_q ? '1 : quo_fix[`MDU_XLEN-1:0];
    assign div.remainder = zero_q ? dvd_q : rem_fix[`MDU_XLEN-1:0];
    assign div.done      = done_q;

    // controller may only start an idle divider
    a_no_start_busy: assert property (@(posedge div.clk) disable iff (!rst_n)
        div.start |-> !busy_q);

endmodule

// File: design/mdu_top.sv
// producer holds at most one request credit; consumer grants MDU_RSP_CREDITS at reset
`timescale 1ns/1ns
`include "mdu_defs.svh"

module mdu_top
    import mdu_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  req_valid,
    input  mdu_op_e               req_op,
    input  logic [`MDU_XLEN-1:0]  req_s1,
    input  logic [`MDU_XLEN-1:0]  req_s2,
    input  logic                  rsp_credit,
    output logic                  req_credit,
    output logic                  rsp_valid,
    output logic [`MDU_XLEN-1:0]  rsp_data
);

    logic                   load_req;
    logic                   load_rsp;
    logic                   is_div;
    logic                   has_credit;
    logic                   mul_start;
    logic                   mul_done;
    logic [`MDU_XLEN:0]     mul_a;
    logic [`MDU_XLEN:0]     mul_b;
    logic [2*`MDU_XLEN+1:0] product;

    // divider handshake bus
    mdu_div_if div_bus (.clk(clk));

    mdu_ctrl ctrl_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .req_valid  (req_valid),
        .is_div     (is_div),
        .mul_done   (mul_done),
        .has_credit (has_credit),
        .req_credit (req_credit),
        .load_req   (load_req),
        .load_rsp   (load_rsp),
        .mul_start  (mul_start),
        .rsp_valid  (rsp_valid),
        .div        (div_bus.ctrl)
    );

    // rsp_valid spends a slot, rsp_credit returns one
    mdu_credit_counter credit_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .take       (rsp_valid),
        .give       (rsp_credit),
        .has_credit (has_credit)
    );

    mdu_dispatch dispatch_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .load_req   (load_req),
        .load_rsp   (load_rsp),
        .req_op     (req_op),
        .req_s1     (req_s1),
        .req_s2     (req_s2),
        .product    (product),
        .is_div     (is_div),
        .mul_a      (mul_a),
        .mul_b      (mul_b),
        .rsp_data   (rsp_data),
        .div        (div_bus.dispatch)
    );

    mdu_multiplier mul_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .mul_start  (mul_start),
        .mul_a      (mul_a),
        .mul_b      (mul_b),
        .product    (product),
        .mul_done   (mul_done)
    );

    mdu_divider div_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .div        (div_bus.divider)
    );

endmodule

// File: dv/mdu_tb.sv
// one request in flight at a time; consumer returns one slot per pulse, with at most 15 idle cycles
`timescale 1ns/1ns
`include "mdu_defs.svh"

module mdu_tb
    import mdu_pkg::*;
();

    localparam int NUM_REQS       = 300;
    localparam int TIMEOUT_CYCLES = NUM_REQS * 60;

    logic                 clk;
    logic                 rst_n;
    logic                 req_valid;
    mdu_op_e              req_op;
    logic [`MDU_XLEN-1:0] req_s1;
    logic [`MDU_XLEN-1:0] req_s2;
    logic                 rsp_credit;
    logic                 req_credit;
    logic                 rsp_valid;
    logic [`MDU_XLEN-1:0] rsp_data;

    // expected results and request text in request order
    logic [`MDU_XLEN-1:0] exp_q[$];
    string                desc_q[$];

    logic [31:0] lfsr_state;
    int          value_errors;
    int          protocol_errors;
    // event counts for the flow-control checks
    int          sent;
    int          received;
    int          returned;
    int          credit_pulses;

    mdu_top dut_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .req_valid  (req_valid),
        .req_op     (req_op),
        .req_s1     (req_s1),
        .req_s2     (req_s2),
        .rsp_credit (rsp_credit),
        .req_credit (req_credit),
        .rsp_valid  (rsp_valid),
        .rsp_data   (rsp_data)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // galois lfsr with taps for x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h8020_0003;
        end
        return s >> 1;
    endfunction

    // one lfsr step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        int          i;
        v = '0;
        for (i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    // RV32M result from 64-bit arithmetic
    function automatic logic [31:0] expected_result(input mdu_op_e op, input logic [31:0] a,
                                                    input logic [31:0] b);
        logic signed [63:0] sa;
        logic signed [63:0] sb;
        logic signed [63:0] ua;
        logic signed [63:0] ub;
        logic [63:0]        p;
        logic [31:0]        r;
        logic               ovf;
        sa  = {{32{a[31]}}, a};
        sb  = {{32{b[31]}}, b};
        ua  = {32'b0, a};
        ub  = {32'b0, b};
        ovf = (a == 32'h8000_0000) && (b == 32'hffff_ffff);
        // mulhsu multiplies signed s1 by unsigned s2
        case (op)
            op_mul, op_mulh: p = sa * sb;
            op_mulhsu:       p = sa * ub;
            default:         p = ua * ub;
        endcase
        // x/0 is all ones, x%0 is x, min/-1 is min rem 0
        case (op)
            op_mul:  r = p[31:0];
            op_div:  r = (b == '0) ? 32'hffff_ffff : ovf ? 32'h8000_0000 : 32'(sa / sb);
            op_divu: r = (b == '0) ? 32'hffff_ffff : 32'(ua / ub);
            op_rem:  r = (b == '0) ? a : ovf ? 32'h0 : 32'(sa % sb);
            op_remu: r = (b == '0) ? a : 32'(ua % ub);
            default: r = p[63:32];
        endcase
        return r;
    endfunction

    // producer followed by the end-of-run checks
    initial begin : main
        mdu_op_e     op;
        logic [31:0] bits;
        logic [31:0] s1;
        logic [31:0] s2;
        lfsr_state      = 32'hdadd;
        value_errors    = 0;
        protocol_errors = 0;
        sent            = 0;
        rst_n           = 1'b0;
        req_valid       = 1'b0;
        req_op          = op_mul;
        req_s1          = '0;
        req_s2          = '0;
        rsp_credit      = 1'b0;
        repeat (4) @(posedge clk);
        #1 rst_n = 1'b1;
        while (sent < NUM_REQS) begin
            @(posedge clk);
            #1;
            // send only while holding a request credit
            if (credit_pulses > sent) begin
                bits = rand_bits(3);
                op   = mdu_op_e'(bits[2:0]);
                s1   = rand_bits(32);
                s2   = rand_bits(32);
                // overflow pair one in sixteen, zero divisor one in eight
                if (rand_bits(4) == 0) begin
                    s1 = 32'h8000_0000;
                    s2 = 32'hffff_ffff;
                end
                if (rand_bits(3) == 0) begin
                    s2 = '0;
                end
                req_valid = 1'b1;
                req_op    = op;
                req_s1    = s1;
                req_s2    = s2;
                exp_q.push_back(expected_result(op, s1, s2));
                desc_q.push_back($sformatf("%s %h %h", op.name(), s1, s2));
                sent++;
                @(posedge clk);
                #1 req_valid = 1'b0;
            end
        end
        // all responses back and every consumer slot returned
        wait (received == NUM_REQS && returned == NUM_REQS);
        repeat (2) @(posedge clk);
        assert (exp_q.size() == 0) else begin
            protocol_errors++;
            $display("%0d results never came back", exp_q.size());
        end
        // initial grant plus one per response
        assert (credit_pulses == NUM_REQS + 1) else begin
            protocol_errors++;
            $display("req_credit pulsed %0d times for %0d responses", credit_pulses, received);
        end
        $display("value errors: %0d, protocol errors: %0d", value_errors, protocol_errors);
        if (value_errors == 0 && protocol_errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

    // outputs sampled on the falling edge between drives
    initial begin : monitor
        logic [31:0] expected;
        string       desc;
        credit_pulses = 0;
        received      = 0;
        forever begin
            @(negedge clk);
            if (rst_n) begin
                if (req_credit) begin
                    credit_pulses++;
                    // single request slot
                    assert (credit_pulses - sent <= 1) else begin
                        protocol_errors++;
                        $display("producer holds two request credits at %0t ns", $time);
                    end
                end
                if (rsp_valid) begin
                    received++;
                    // free consumer slots must not go negative
                    assert (`MDU_RSP_CREDITS - received + returned >= 0) else begin
                        protocol_errors++;
                        $display("response sent with no free consumer slot at %0t ns", $time);
                    end
                    assert (exp_q.size() > 0) else begin
                        protocol_errors++;
                        $display("response arrived with no request outstanding at %0t ns", $time);
                    end
                    if (exp_q.size() > 0) begin
                        expected = exp_q.pop_front();
                        desc     = desc_q.pop_front();
                        assert (rsp_data === expected) else begin
                            value_errors++;
                            $display("error at %0t ns: %s gave %h, expected %h",
                                     $time, desc, rsp_data, expected);
                        end
                    end
                end
            end
        end
    end

    // consumer frees slots one pulse at a time
    initial begin : credit_return
        int delay;
        returned = 0;
        wait (rst_n === 1'b1);
        forever begin
            @(posedge clk);
            if (received > returned) begin
                // 0 to 15 idle cycles
                delay = rand_bits(4);
                repeat (delay) @(posedge clk);
                #1 rsp_credit = 1'b1;
                @(posedge clk);
                #1 rsp_credit = 1'b0;
                returned++;
            end
        end
    end

    initial begin : watchdog
        repeat (TIMEOUT_CYCLES) @(posedge clk);
        $display("timeout: the unit hung after %0d of %0d responses", received, NUM_REQS);
        $display("value errors: %0d, protocol errors: %0d", value_errors, protocol_errors);
        $display("Finished with errors");
        $finish;
    end

endmodule

// File: list.f
+incdir+include
design/mdu_pkg.sv
design/mdu_div_if.sv
design/mdu_ctrl.sv
design/mdu_credit_counter.sv
design/mdu_dispatch.sv
design/mdu_multiplier.sv
design/mdu_divider.sv
design/mdu_top.sv
dv/mdu_tb.sv

// File: Makefile
TOP := mdu_tb

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -f list.f --top-module $(TOP) -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "Finished with no errors"

clean:
	rm -rf obj_dir
